/* design/datapathPkg.sv */
package datapathPkg;

    localparam int wordWidth = 32;
    localparam int numRegs = 16;
    localparam int constWidth = 19;   // IR immediate field, bits 18:0

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [2*wordWidth-1:0] dword_t;     // full ALU result, held in Z
    typedef logic [numRegs-1:0] regSel_t;        // one bit per general register
    typedef logic [4:0] aluOp_t;

    // ALU opcodes
    localparam aluOp_t opAdd = 5'd0;
    localparam aluOp_t opSub = 5'd1;
    localparam aluOp_t opOr = 5'd2;
    localparam aluOp_t opAnd = 5'd3;

    // shifts and rotates, amount from low five bits of the bus
    localparam aluOp_t opShr = 5'd4;
    localparam aluOp_t opShra = 5'd5;
    localparam aluOp_t opShl = 5'd6;
    localparam aluOp_t opRor = 5'd7;
    localparam aluOp_t opRol = 5'd8;

    localparam aluOp_t opMul = 5'd9;    // signed, 64-bit result
    localparam aluOp_t opNeg = 5'd10;
    localparam aluOp_t opNot = 5'd11;

endpackage

/* design/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                 Clock,
    input  logic                 reset,
    input  datapathPkg::regSel_t regIn,
    input  datapathPkg::regSel_t regOut,
    input  datapathPkg::word_t   busValue,
    output datapathPkg::word_t   readValue,
    output logic                 readValid
);

    datapathPkg::word_t regs [datapathPkg::numRegs];

    genvar i;
    generate
        for (i = 0; i < datapathPkg::numRegs; i++) begin : genReg
            always_ff @(posedge Clock) begin
                if (reset) begin
                    regs[i] <= '0;
                end else if (regIn[i]) begin
                    regs[i] <= busValue;   // capture the bus
                end
            end
        end
    endgenerate

    // lowest set out bit wins, so walk down and let the last hit stand
    always_comb begin
        readValue = '0;
        readValid = 1'b0;
        for (int k = datapathPkg::numRegs - 1; k >= 0; k--) begin
            if (regOut[k]) begin
                readValue = regs[k];
                readValid = 1'b1;
            end
        end
    end

endmodule

/* design/busSourceMux.sv */
`timescale 1ns/1ps

module busSourceMux (
    input  datapathPkg::word_t  regValue,
    input  logic                regValid,
    input  logic                hiOut,
    input  logic                loOut,
    input  logic                zHighOut,
    input  logic                zLowOut,
    input  logic                pcOut,
    input  logic                mdrOut,
    input  logic                inPortOut,
    input  logic                cOut,
    input  datapathPkg::word_t  hiValue,
    input  datapathPkg::word_t  loValue,
    input  datapathPkg::dword_t zValue,
    input  datapathPkg::word_t  pcValue,
    input  datapathPkg::word_t  mdrValue,
    input  datapathPkg::word_t  inPortValue,
    input  datapathPkg::word_t  irValue,
    output datapathPkg::word_t  busValue
);

    localparam int extBits = datapathPkg::wordWidth - datapathPkg::constWidth;

    datapathPkg::word_t cValue;

    // immediate field of the IR, sign-extended to a full word
    assign cValue = {{extBits{irValue[datapathPkg::constWidth-1]}},
                     irValue[datapathPkg::constWidth-1:0]};

    // general registers first, then special registers, then port and constant
    always_comb begin
        if (regValid) begin
            busValue = regValue;
        end else if (hiOut) begin
            busValue = hiValue;
        end else if (loOut) begin
            busValue = loValue;
        end else if (zHighOut) begin
            busValue = zValue[2*datapathPkg::wordWidth-1:datapathPkg::wordWidth];
        end else if (zLowOut) begin
            busValue = zValue[datapathPkg::wordWidth-1:0];
        end else if (pcOut) begin
            busValue = pcValue;
        end else if (mdrOut) begin
            busValue = mdrValue;
        end else if (inPortOut) begin
            busValue = inPortValue;
        end else if (cOut) begin
            busValue = cValue;
        end else begin
            busValue = '0;   // idle bus
        end
    end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  datapathPkg::word_t  yValue,
    input  datapathPkg::word_t  busValue,
    input  datapathPkg::aluOp_t opcode,
    output datapathPkg::dword_t result
);

    localparam int w = datapathPkg::wordWidth;

    datapathPkg::word_t a;
    datapathPkg::word_t b;
    logic [4:0] shamt;
    logic signed [2*w-1:0] product;
    datapathPkg::dword_t rorWide;
    datapathPkg::dword_t rolWide;
    datapathPkg::word_t low;

    assign a = yValue;       // operand A from Y
    assign b = busValue;     // operand B straight off the bus
    assign shamt = b[4:0];

    // both operands sign-extend to 64 bits before the multiply
    assign product = $signed(a) * $signed(b);

    // rotate by shifting a doubled copy of A
    assign rorWide = {a, a} >> shamt;
    assign rolWide = {a, a} << shamt;

    always_comb begin
        low = '0;
        case (opcode)
            datapathPkg::opAdd: begin
                low = a + b;
            end
            datapathPkg::opSub: begin
                low = a - b;
            end
            datapathPkg::opOr: begin
                low = a | b;
            end
            datapathPkg::opAnd: begin
                low = a & b;
            end
            datapathPkg::opShr: begin
                low = a >> shamt;
            end
            datapathPkg::opShra: begin
                low = $signed(a) >>> shamt;   // sign bit fills from the top
            end
            datapathPkg::opShl: begin
                low = a << shamt;
            end
            datapathPkg::opRor: begin
                low = rorWide[w-1:0];
            end
            datapathPkg::opRol: begin
                low = rolWide[2*w-1:w];
            end
            datapathPkg::opMul: begin
                low = product[w-1:0];
            end
            datapathPkg::opNeg: begin
                low = -b;   // two's complement of B only
            end
            datapathPkg::opNot: begin
                low = ~b;
            end
            default: begin
                low = '0;   // unused codes give zero
            end
        endcase
    end

    // only the multiply uses the upper half
    assign result = (opcode == datapathPkg::opMul) ? product : {{w{1'b0}}, low};

endmodule

/* design/specialRegisters.sv */
`timescale 1ns/1ps

module specialRegisters (
    input  logic                Clock,
    input  logic                reset,
    input  datapathPkg::word_t  busValue,
    input  datapathPkg::dword_t aluResult,
    input  logic                pcIn,
    input  logic                incPc,
    input  logic                irIn,
    input  logic                marIn,
    input  logic                mdrIn,
    input  logic                read,
    input  datapathPkg::word_t  memData,
    input  logic                yIn,
    input  logic                zIn,
    input  logic                hiIn,
    input  logic                loIn,
    output datapathPkg::word_t  pcValue,
    output datapathPkg::word_t  irValue,
    output datapathPkg::word_t  marValue,
    output datapathPkg::word_t  mdrValue,
    output datapathPkg::word_t  yValue,
    output datapathPkg::word_t  hiValue,
    output datapathPkg::word_t  loValue,
    output datapathPkg::dword_t zValue
);

    datapathPkg::word_t mdrNext;

    // memory data when reading, otherwise the bus
    assign mdrNext = read ? memData : busValue;

    always_ff @(posedge Clock) begin
        if (reset) begin
            pcValue <= '0;
            irValue <= '0;
            marValue <= '0;
            mdrValue <= '0;
            yValue <= '0;
            zValue <= '0;
            hiValue <= '0;
            loValue <= '0;
        end else begin
            // a bus load beats the increment
            if (pcIn) begin
                pcValue <= busValue;
            end else if (incPc) begin
                pcValue <= pcValue + 32'd1;
            end

            if (irIn) irValue <= busValue;
            if (marIn) marValue <= busValue;   // drives the memory address
            if (mdrIn) mdrValue <= mdrNext;
            if (yIn) yValue <= busValue;
            if (zIn) zValue <= aluResult;      // full 64-bit result
            if (hiIn) hiValue <= busValue;
            if (loIn) loValue <= busValue;
        end
    end

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic                 Clock,
    input  logic                 reset,
    input  datapathPkg::regSel_t regIn,
    input  datapathPkg::regSel_t regOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 pcOut,
    input  logic                 mdrOut,
    input  logic                 inPortOut,
    input  logic                 cOut,
    input  logic                 pcIn,
    input  logic                 incPc,
    input  logic                 irIn,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 read,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  datapathPkg::aluOp_t  opcode,
    input  datapathPkg::word_t   memData,
    input  datapathPkg::word_t   inPortData,
    output datapathPkg::word_t   busValue,
    output datapathPkg::word_t   address
);

    datapathPkg::word_t regValue;
    logic regValid;
    datapathPkg::dword_t aluResult;
    datapathPkg::word_t pcValue;
    datapathPkg::word_t irValue;
    datapathPkg::word_t mdrValue;
    datapathPkg::word_t yValue;
    datapathPkg::word_t hiValue;
    datapathPkg::word_t loValue;
    datapathPkg::dword_t zValue;

    registerFile u_registerFile (
        .Clock(Clock),
        .reset(reset),
        .regIn(regIn),
        .regOut(regOut),
        .busValue(busValue),
        .readValue(regValue),
        .readValid(regValid)
    );

    // the one shared bus
    busSourceMux u_busSourceMux (
        .regValue(regValue),
        .regValid(regValid),
        .hiOut(hiOut),
        .loOut(loOut),
        .zHighOut(zHighOut),
        .zLowOut(zLowOut),
        .pcOut(pcOut),
        .mdrOut(mdrOut),
        .inPortOut(inPortOut),
        .cOut(cOut),
        .hiValue(hiValue),
        .loValue(loValue),
        .zValue(zValue),
        .pcValue(pcValue),
        .mdrValue(mdrValue),
        .inPortValue(inPortData),
        .irValue(irValue),
        .busValue(busValue)
    );

    alu u_alu (
        .yValue(yValue),
        .busValue(busValue),
        .opcode(opcode),
        .result(aluResult)
    );

    specialRegisters u_specialRegisters (
        .Clock(Clock),
        .reset(reset),
        .busValue(busValue),
        .aluResult(aluResult),
        .pcIn(pcIn),
        .incPc(incPc),
        .irIn(irIn),
        .marIn(marIn),
        .mdrIn(mdrIn),
        .read(read),
        .memData(memData),
        .yIn(yIn),
        .zIn(zIn),
        .hiIn(hiIn),
        .loIn(loIn),
        .pcValue(pcValue),
        .irValue(irValue),
        .marValue(address),   // MAR goes straight out as the address
        .mdrValue(mdrValue),
        .yValue(yValue),
        .hiValue(hiValue),
        .loValue(loValue),
        .zValue(zValue)
    );

endmodule

/* tests/datapath_props.sv */
`timescale 1ns/1ps

module datapathProps (
    input logic                 Clock,
    input logic                 reset,
    input datapathPkg::regSel_t regOut,
    input logic                 hiOut,
    input logic                 loOut,
    input logic                 zHighOut,
    input logic                 zLowOut,
    input logic                 pcOut,
    input logic                 mdrOut,
    input logic                 inPortOut,
    input logic                 cOut,
    input logic                 zIn,
    input logic                 marIn,
    input datapathPkg::aluOp_t  opcode,
    input datapathPkg::word_t   busValue,
    input datapathPkg::word_t   address,
    input datapathPkg::word_t   yValue
);

    logic anySource;
    logic zLowAlone;
    int failures = 0;   // read by the testbench summary

    assign anySource = (|regOut) || hiOut || loOut || zHighOut || zLowOut
                       || pcOut || mdrOut || inPortOut || cOut;
    assign zLowAlone = zLowOut && !(|regOut) && !hiOut && !loOut && !zHighOut;

    idleBusZero: assert property (@(posedge Clock) disable iff (reset)
        !anySource |-> busValue == '0)
        else begin
            $error("bus not zero with no source selected");
            failures++;
        end

    // Z low half one step after an and
    andThroughZ: assert property (@(posedge Clock) disable iff (reset)
        $past(zIn) && $past(opcode) == datapathPkg::opAnd && zLowAlone
        |-> busValue == ($past(yValue) & $past(busValue)))
        else begin
            $error("Z low half does not hold Y and bus");
            failures++;
        end

    marFollowsBus: assert property (@(posedge Clock) disable iff (reset)
        marIn |=> address == $past(busValue))
        else begin
            $error("address does not follow the bus after marIn");
            failures++;
        end

endmodule

bind datapath datapathProps u_datapathProps (.*);

/* tests/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;

    localparam int testCycles = 140;             // rough sum of all test lengths
    localparam int cycleLimit = 2 * testCycles;

    logic Clock;
    logic reset;
    datapathPkg::regSel_t regIn;
    datapathPkg::regSel_t regOut;
    logic hiOut, loOut, zHighOut, zLowOut;       // bus sources
    logic pcOut, mdrOut, inPortOut, cOut;
    logic pcIn, incPc, irIn, marIn, mdrIn, read; // loads
    logic yIn, zIn, hiIn, loIn;
    datapathPkg::aluOp_t opcode;
    datapathPkg::word_t memData;
    datapathPkg::word_t inPortData;
    datapathPkg::word_t busValue;
    datapathPkg::word_t address;

    datapathPkg::word_t regModel [datapathPkg::numRegs] = '{default: '0};
    datapathPkg::word_t data, opA, opB;
    datapathPkg::word_t pcStart, instr;
    datapathPkg::dword_t zModel;
    logic [31:0] lfsr;
    int cycles;
    int errors;
    int errorsAtStart;
    int testsRun;
    int testsFailed;

    datapath u_datapath (.*);

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    always @(posedge Clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic datapathPkg::word_t randomWord();
        datapathPkg::word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsrNext(lfsr);    // one step per bit
            w = {w[30:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic datapathPkg::regSel_t oneHot(input int r);
        return datapathPkg::regSel_t'(1) << r;
    endfunction

    // what Z should hold with Y = a and bus = b
    function automatic datapathPkg::dword_t expectZ(input datapathPkg::aluOp_t op,
                                                    input datapathPkg::word_t a,
                                                    input datapathPkg::word_t b);
        int n;
        longint prod;
        n = int'(b[4:0]);
        prod = longint'($signed(a)) * longint'($signed(b));
        case (op)
            datapathPkg::opAdd: return {32'd0, a + b};
            datapathPkg::opSub: return {32'd0, a - b};
            datapathPkg::opOr: return {32'd0, a | b};
            datapathPkg::opAnd: return {32'd0, a & b};
            datapathPkg::opShr: return {32'd0, a >> n};
            datapathPkg::opShra: return {32'd0, $signed(a) >>> n};
            datapathPkg::opShl: return {32'd0, a << n};
            datapathPkg::opRor: return {32'd0, (a >> n) | (a << (32 - n))};
            datapathPkg::opRol: return {32'd0, (a << n) | (a >> (32 - n))};
            datapathPkg::opMul: return prod;
            datapathPkg::opNeg: return {32'd0, 32'd0 - b};
            datapathPkg::opNot: return {32'd0, ~b};
            default: return '0;
        endcase
    endfunction

    // value checks plus failed bound assertions
    function automatic int totalErrors();
        return errors + u_datapath.u_datapathProps.failures;
    endfunction

    task automatic checkValue(input string name, input datapathPkg::word_t actual,
                              input datapathPkg::word_t expected);
        assert (actual === expected) else begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic clearLines();
        regIn <= '0;
        regOut <= '0;
        {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut} <= '0;
        {pcIn, incPc, irIn, marIn, mdrIn, read, yIn, zIn, hiIn, loIn} <= '0;
    endtask

    // next control step, previous lines dropped
    task automatic nextStep();
        @(posedge Clock);
        clearLines();
    endtask

    task automatic expectBus(input datapathPkg::word_t expected);
        @(negedge Clock);   // lines and bus settled by now
        checkValue("busValue", busValue, expected);
    endtask

    task automatic loadMdr(input datapathPkg::word_t value);
        nextStep();
        memData <= value;
        read <= 1'b1;
        mdrIn <= 1'b1;
    endtask

    task automatic loadReg(input int r, input datapathPkg::word_t value);
        loadMdr(value);
        nextStep();
        mdrOut <= 1'b1;
        regIn <= oneHot(r);
        regModel[r] = value;
    endtask

    task automatic showReg(input int r);
        nextStep();
        regOut <= oneHot(r);
        expectBus(regModel[r]);
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (totalErrors() != errorsAtStart) begin
            testsFailed++;
            $display("test %0d %s: failed", testsRun, name);
        end else begin
            $display("test %0d %s: ok", testsRun, name);
        end
        errorsAtStart = totalErrors();
    endtask

    initial begin
        lfsr = 32'h3b77;
        reset <= 1'b1;
        opcode <= datapathPkg::opAdd;
        memData <= '0;
        inPortData <= '0;
        clearLines();
        repeat (5) @(posedge Clock);
        reset <= 1'b0;

        for (int r = 0; r < datapathPkg::numRegs; r++) begin
            showReg(r);
        end
        for (int k = 0; k < 6; k++) begin
            nextStep();
            {hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut} <= 6'b100000 >> k;
            expectBus('0);
        end
        checkValue("address", address, '0);
        endTest("reset values");

        for (int r = 0; r < datapathPkg::numRegs; r++) begin
            loadReg(r, randomWord());
            showReg(r);
        end
        endTest("memory load path");

        opA = randomWord() | 32'h8000_0000;   // negative Y for mul and shra
        opB = randomWord();
        loadReg(1, opA);
        loadReg(2, opB);
        nextStep();
        regOut <= oneHot(1);
        yIn <= 1'b1;
        for (int op = 0; op < 12; op++) begin
            zModel = expectZ(datapathPkg::aluOp_t'(op), opA, opB);
            nextStep();
            regOut <= oneHot(2);
            zIn <= 1'b1;
            opcode <= datapathPkg::aluOp_t'(op);
            nextStep();
            zLowOut <= 1'b1;
            expectBus(zModel[31:0]);
            nextStep();
            zHighOut <= 1'b1;
            expectBus(zModel[63:32]);
        end
        endTest("alu opcodes");

        pcStart = randomWord();
        loadMdr(pcStart);
        nextStep();
        mdrOut <= 1'b1;
        pcIn <= 1'b1;
        nextStep();
        yIn <= 1'b1;        // idle bus clears Y
        nextStep();
        pcOut <= 1'b1;
        marIn <= 1'b1;
        zIn <= 1'b1;
        incPc <= 1'b1;
        opcode <= datapathPkg::opAdd;
        nextStep();
        pcOut <= 1'b1;
        expectBus(pcStart + 32'd1);
        checkValue("address", address, pcStart);
        nextStep();
        zLowOut <= 1'b1;
        pcIn <= 1'b1;
        nextStep();
        pcOut <= 1'b1;
        expectBus(pcStart);
        endTest("fetch step");

        for (int k = 0; k < 2; k++) begin
            instr = randomWord();
            instr[18] = k[0];   // positive immediate, then negative
            loadMdr(instr);
            nextStep();
            mdrOut <= 1'b1;
            irIn <= 1'b1;
            nextStep();
            cOut <= 1'b1;
            expectBus({{13{instr[18]}}, instr[18:0]});
        end
        endTest("constant source");

        nextStep();
        regOut <= oneHot(9) | oneHot(4);
        expectBus(regModel[4]);
        data = randomWord();
        nextStep();
        inPortData <= data;
        inPortOut <= 1'b1;
        hiIn <= 1'b1;
        expectBus(data);
        nextStep();
        regOut <= oneHot(7);
        loIn <= 1'b1;
        nextStep();
        hiOut <= 1'b1;
        expectBus(data);
        nextStep();
        loOut <= 1'b1;
        expectBus(regModel[7]);
        endTest("priority and ports");

        nextStep();
        @(negedge Clock);   // last edge's assertions have run
        $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed,
                 totalErrors());
        if (testsFailed == 0 && totalErrors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
design/datapathPkg.sv
design/registerFile.sv
design/busSourceMux.sv
design/alu.sv
design/specialRegisters.sv
design/datapath.sv
tests/datapath_props.sv
tests/datapathTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= datapathTb
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-$(SIM) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
